/* redmule_pkg.sv */
// Shared types and the register map; offsets are laid out for the default 4x4 tile only
`default_nettype none

package redmule_pkg;

  // Matrix elements are 16-bit two's complement, all arithmetic wraps
  localparam int unsigned ELEM_W = 16;
  typedef logic [ELEM_W-1:0] elem_t;

  localparam int unsigned AXI_ADDR_W = 8;
  localparam int unsigned AXI_DATA_W = 32;

  // Register map, two elements per 32-bit word
  localparam logic [AXI_ADDR_W-1:0] X_BASE       = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] W_BASE       = 8'h20;
  localparam logic [AXI_ADDR_W-1:0] Y_BASE       = 8'h28;
  localparam logic [AXI_ADDR_W-1:0] Z_BASE       = 8'h30;
  localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR  = 8'h50;
  localparam logic [AXI_ADDR_W-1:0] TRIGGER_ADDR = 8'h54;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Target of an operand write
  typedef enum logic [1:0] {
    SEL_X = 2'd0,
    SEL_W = 2'd1,
    SEL_Y = 2'd2
  } mat_sel_e;

  // Lower element sits at the lower element index
  typedef struct packed {
    elem_t hi;
    elem_t lo;
  } elem_pair_t;

  typedef struct packed {
    logic [AXI_DATA_W-3:0] rsvd;
    logic                  clear;
    logic                  start;
  } cmd_t;

  // One write word, read as an operand pair or as a trigger command
  typedef union packed {
    elem_pair_t pair;
    cmd_t       cmd;
  } wdata_u;

endpackage

`default_nettype wire

/* redmule_load_if.sv */
// Operand write bus with no back-pressure; a write is taken in the cycle valid is high
`timescale 1ns/10ps
`default_nettype none

interface redmule_load_if;
  import redmule_pkg::*;

  logic                  valid;
  mat_sel_e              sel;
  // Word index relative to the base of the selected operand
  logic [AXI_ADDR_W-3:0] index;
  // Element [0] goes to the even element index
  elem_t [1:0]           data;

  modport master (
    output valid,
    output sel,
    output index,
    output data
  );

  modport buffer (
    input valid,
    input sel,
    input index,
    input data
  );

endinterface

`default_nettype wire

/* redmule_ctrl_slave.sv */
// AXI4-Lite slave taking full-word writes only (partial strobes get SLVERR); Width must be even
`timescale 1ns/10ps
`default_nettype none

module redmule_ctrl_slave #(
  parameter int unsigned Width  = 4,
  parameter int unsigned Height = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [redmule_pkg::AXI_ADDR_W-1:0]    awaddr_i,
  input  logic                                  awvalid_i,
  output logic                                  awready_o,
  input  logic [redmule_pkg::AXI_DATA_W-1:0]    wdata_i,
  input  logic [redmule_pkg::AXI_DATA_W/8-1:0]  wstrb_i,
  input  logic                                  wvalid_i,
  output logic                                  wready_o,
  output logic [1:0]                            bresp_o,
  output logic                                  bvalid_o,
  input  logic                                  bready_i,
  input  logic [redmule_pkg::AXI_ADDR_W-1:0]    araddr_i,
  input  logic                                  arvalid_i,
  output logic                                  arready_o,
  output logic [redmule_pkg::AXI_DATA_W-1:0]    rdata_o,
  output logic [1:0]                            rresp_o,
  output logic                                  rvalid_o,
  input  logic                                  rready_i,
  input  logic                                  busy_i,
  input  logic                                  done_i,
  input  logic                                  w_loaded_i,
  input  redmule_pkg::elem_t [Width-1:0]        z_i,
  output logic                                  start_o,
  output logic                                  clear_o,
  redmule_load_if.master                        load_if
);
  import redmule_pkg::*;

  localparam int unsigned XWords = Width * Height / 2;
  localparam int unsigned WWords = Height / 2;
  localparam int unsigned YWords = Width / 2;

  logic                  aw_hs;
  logic                  ar_hs;
  wdata_u                wd;
  logic                  full_strb;
  logic                  wr_x;
  logic                  wr_w;
  logic                  wr_y;
  logic                  wr_trig;
  logic                  wr_oper;
  logic                  wr_ok;
  mat_sel_e              wr_sel;
  logic [AXI_ADDR_W-1:0] wr_base;
  logic [AXI_ADDR_W-1:0] wr_rel;
  logic [AXI_ADDR_W-1:0] rd_rel;
  logic                  rd_z;
  logic                  rd_ok;
  logic [AXI_DATA_W-1:0] rd_data;
  logic                  bvalid_q;
  logic [1:0]            bresp_q;
  logic                  rvalid_q;
  logic [1:0]            rresp_q;
  logic [AXI_DATA_W-1:0] rdata_q;

  function automatic logic in_region(input logic [AXI_ADDR_W-1:0] addr,
                                     input logic [AXI_ADDR_W-1:0] base,
                                     input int unsigned           words);
    return (addr >= base) && (32'(addr) < 32'(base) + 4 * words);
  endfunction

  // Address and data are taken together, one write in flight at a time
  assign aw_hs     = awvalid_i && wvalid_i && !bvalid_q;
  assign awready_o = aw_hs;
  assign wready_o  = aw_hs;
  assign wd        = wdata_i;
  assign full_strb = &wstrb_i;

  always_comb begin
    wr_x    = in_region(awaddr_i, X_BASE, XWords);
    wr_w    = in_region(awaddr_i, W_BASE, WWords);
    wr_y    = in_region(awaddr_i, Y_BASE, YWords);
    wr_trig = (awaddr_i == TRIGGER_ADDR) && full_strb;
    // Operands are frozen while a job runs
    wr_oper = (wr_x || wr_w || wr_y) && full_strb && !busy_i;
    wr_ok   = wr_oper || wr_trig;
    wr_sel  = SEL_X;
    wr_base = X_BASE;
    if (wr_w) begin
      wr_sel  = SEL_W;
      wr_base = W_BASE;
    end else if (wr_y) begin
      wr_sel  = SEL_Y;
      wr_base = Y_BASE;
    end
    wr_rel = awaddr_i - wr_base;
  end

  assign load_if.valid = aw_hs && wr_oper;
  assign load_if.sel   = wr_sel;
  assign load_if.index = wr_rel[AXI_ADDR_W-1:2];
  assign load_if.data  = {wd.pair.hi, wd.pair.lo};

  assign start_o = aw_hs && wr_trig && wd.cmd.start;
  assign clear_o = aw_hs && wr_trig && wd.cmd.clear;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RESP_OKAY;
    end else if (aw_hs) begin
      bvalid_q <= 1'b1;
      bresp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  // Only Z and STATUS are readable
  always_comb begin
    rd_rel  = araddr_i - Z_BASE;
    rd_z    = in_region(araddr_i, Z_BASE, YWords);
    rd_ok   = rd_z || (araddr_i == STATUS_ADDR);
    rd_data = '0;
    for (int j = 0; j < Width / 2; j++) begin
      if (rd_z && rd_rel[AXI_ADDR_W-1:2] == j) begin
        rd_data = {z_i[2*j+1], z_i[2*j]};
      end
    end
    if (araddr_i == STATUS_ADDR) begin
      rd_data = {{(AXI_DATA_W-3){1'b0}}, w_loaded_i, done_i, busy_i};
    end
  end

  assign ar_hs     = arvalid_i && !rvalid_q;
  assign arready_o = !rvalid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rresp_q  <= RESP_OKAY;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
      rresp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rd_data;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

  // A write response may not be withdrawn before the master takes it
  a_bvalid_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

`default_nettype wire

/* redmule_x_buffer.sv */
// X tile store in row-major order; Width*Height must be even, contents zeroed by reset and clear
`timescale 1ns/10ps
`default_nettype none

module redmule_x_buffer #(
  parameter int unsigned Width  = 4,
  parameter int unsigned Height = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           clear_i,
  redmule_load_if.buffer                 load_if,
  input  logic [$clog2(Height)-1:0]      step_i,
  output redmule_pkg::elem_t [Width-1:0] x_col_o
);
  import redmule_pkg::*;

  localparam int unsigned NumPairs = Width * Height / 2;

  elem_t [Width*Height-1:0] x_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      x_q <= '0;
    end else if (load_if.valid && load_if.sel == SEL_X) begin
      for (int p = 0; p < NumPairs; p++) begin
        if (load_if.index == p) begin
          x_q[2*p]   <= load_if.data[0];
          x_q[2*p+1] <= load_if.data[1];
        end
      end
    end
  end

  // Column step_i feeds one accumulation step of every row
  always_comb begin
    for (int r = 0; r < Width; r++) begin
      x_col_o[r] = x_q[r*Height + int'(step_i)];
    end
  end

  // The slave range check must keep X writes inside the tile
  a_x_index : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_if.valid && load_if.sel == SEL_X |-> load_if.index < NumPairs);

endmodule

`default_nettype wire

/* redmule_w_buffer.sv */
// W vector store; Height must be even and w_loaded needs every element written since clear
`timescale 1ns/10ps
`default_nettype none

module redmule_w_buffer #(
  parameter int unsigned Height = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  redmule_load_if.buffer            load_if,
  input  logic [$clog2(Height)-1:0] step_i,
  output redmule_pkg::elem_t        w_o,
  output logic                      w_loaded_o
);
  import redmule_pkg::*;

  elem_t [Height-1:0] w_q;
  logic  [Height-1:0] written_q;
  logic               w_wr;

  assign w_wr = load_if.valid && load_if.sel == SEL_W;

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < Height / 2; p++) begin
      if (w_wr && load_if.index == p) begin
        w_q[2*p]   <= load_if.data[0];
        w_q[2*p+1] <= load_if.data[1];
      end
    end
  end

  // Written mask, both halves of a pair land together
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      written_q <= '0;
    end else begin
      for (int p = 0; p < Height / 2; p++) begin
        if (w_wr && load_if.index == p) begin
          written_q[2*p+1 -: 2] <= 2'b11;
        end
      end
    end
  end

  assign w_o        = w_q[step_i];
  assign w_loaded_o = &written_q;

endmodule

`default_nettype wire

/* redmule_engine.sv */
// Job sequencer and multiply-accumulate rows; a job stays busy for Height+2 cycles, Width even
`timescale 1ns/10ps
`default_nettype none

module redmule_engine #(
  parameter int unsigned Width  = 4,
  parameter int unsigned Height = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  logic                           clear_i,
  redmule_load_if.buffer                 load_if,
  input  redmule_pkg::elem_t [Width-1:0] x_col_i,
  input  redmule_pkg::elem_t             w_i,
  input  logic                           w_loaded_i,
  output logic [$clog2(Height)-1:0]      step_o,
  output logic                           busy_o,
  output logic                           done_o,
  output redmule_pkg::elem_t [Width-1:0] z_o
);
  import redmule_pkg::*;

  localparam int unsigned StepW = $clog2(Height);
  localparam int unsigned CntW  = $clog2(Height + 2);

  elem_t [Width-1:0] y_q;
  elem_t [Width-1:0] prod_q;
  elem_t [Width-1:0] acc_q;
  logic  [CntW-1:0]  cnt_q;
  logic              busy_q;
  logic              done_q;
  logic              prod_vld_q;
  logic              start_ok;
  logic              issue;

  // Y bias is written through the same operand bus
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < Width / 2; p++) begin
      if (load_if.valid && load_if.sel == SEL_Y && load_if.index == p) begin
        y_q[2*p]   <= load_if.data[0];
        y_q[2*p+1] <= load_if.data[1];
      end
    end
  end

  assign start_ok = start_i && !busy_q && w_loaded_i;
  // Steps 0..Height-1 issue, the last two counts drain the pipeline
  assign issue    = busy_q && (cnt_q < CntW'(Height));
  assign step_o   = issue ? cnt_q[StepW-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      cnt_q      <= '0;
      prod_vld_q <= 1'b0;
    end else begin
      prod_vld_q <= issue;
      if (start_ok) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        cnt_q  <= '0;
      end else if (busy_q) begin
        if (cnt_q == CntW'(Height + 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Multiply stage, products wrap to 16 bits
  always_ff @(posedge clk_i) begin
    for (int r = 0; r < Width; r++) begin
      prod_q[r] <= x_col_i[r] * w_i;
    end
  end

  // Accumulate stage, seeded with the bias when a job starts
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      acc_q <= '0;
    end else if (start_ok) begin
      acc_q <= y_q;
    end else if (prod_vld_q) begin
      for (int r = 0; r < Width; r++) begin
        acc_q[r] <= acc_q[r] + prod_q[r];
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;
  assign z_o    = acc_q;

  // Step counter never runs past the drain, so buffer indexing stays inside the W vector
  a_cnt_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    int'(cnt_q) <= Height + 1);

endmodule

`default_nettype wire

/* redmule_top.sv */
// Accelerator top with AXI4-Lite ports; Width and Height even, offsets fixed for the 4x4 map
`timescale 1ns/10ps
`default_nettype none

module redmule_top #(
  parameter int unsigned Width  = 4,
  parameter int unsigned Height = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [redmule_pkg::AXI_ADDR_W-1:0]   awaddr_i,
  input  logic                                 awvalid_i,
  output logic                                 awready_o,
  input  logic [redmule_pkg::AXI_DATA_W-1:0]   wdata_i,
  input  logic [redmule_pkg::AXI_DATA_W/8-1:0] wstrb_i,
  input  logic                                 wvalid_i,
  output logic                                 wready_o,
  output logic [1:0]                           bresp_o,
  output logic                                 bvalid_o,
  input  logic                                 bready_i,
  input  logic [redmule_pkg::AXI_ADDR_W-1:0]   araddr_i,
  input  logic                                 arvalid_i,
  output logic                                 arready_o,
  output logic [redmule_pkg::AXI_DATA_W-1:0]   rdata_o,
  output logic [1:0]                           rresp_o,
  output logic                                 rvalid_o,
  input  logic                                 rready_i
);
  import redmule_pkg::*;

  logic                      start;
  logic                      clear;
  logic                      busy;
  logic                      done;
  logic                      w_loaded;
  elem_t [Width-1:0]         z;
  elem_t [Width-1:0]         x_col;
  elem_t                     w_elem;
  logic [$clog2(Height)-1:0] step;

  redmule_load_if load_if ();

  redmule_ctrl_slave #(
    .Width  ( Width  ),
    .Height ( Height )
  ) i_ctrl_slave (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .awaddr_i   ( awaddr_i  ),
    .awvalid_i  ( awvalid_i ),
    .awready_o  ( awready_o ),
    .wdata_i    ( wdata_i   ),
    .wstrb_i    ( wstrb_i   ),
    .wvalid_i   ( wvalid_i  ),
    .wready_o   ( wready_o  ),
    .bresp_o    ( bresp_o   ),
    .bvalid_o   ( bvalid_o  ),
    .bready_i   ( bready_i  ),
    .araddr_i   ( araddr_i  ),
    .arvalid_i  ( arvalid_i ),
    .arready_o  ( arready_o ),
    .rdata_o    ( rdata_o   ),
    .rresp_o    ( rresp_o   ),
    .rvalid_o   ( rvalid_o  ),
    .rready_i   ( rready_i  ),
    .busy_i     ( busy      ),
    .done_i     ( done      ),
    .w_loaded_i ( w_loaded  ),
    .z_i        ( z         ),
    .start_o    ( start     ),
    .clear_o    ( clear     ),
    .load_if    ( load_if   )
  );

  redmule_x_buffer #(
    .Width  ( Width  ),
    .Height ( Height )
  ) i_x_buffer (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .clear_i ( clear   ),
    .load_if ( load_if ),
    .step_i  ( step    ),
    .x_col_o ( x_col   )
  );

  redmule_w_buffer #(
    .Height ( Height )
  ) i_w_buffer (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .clear_i    ( clear    ),
    .load_if    ( load_if  ),
    .step_i     ( step     ),
    .w_o        ( w_elem   ),
    .w_loaded_o ( w_loaded )
  );

  redmule_engine #(
    .Width  ( Width  ),
    .Height ( Height )
  ) i_engine (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .start_i    ( start    ),
    .clear_i    ( clear    ),
    .load_if    ( load_if  ),
    .x_col_i    ( x_col    ),
    .w_i        ( w_elem   ),
    .w_loaded_i ( w_loaded ),
    .step_o     ( step     ),
    .busy_o     ( busy     ),
    .done_o     ( done     ),
    .z_o        ( z        )
  );

endmodule

`default_nettype wire

/* tb_redmule.sv */
// Testbench for the default 4x4 register map only; it stops at the first failing check
`timescale 1ns/10ps
`default_nettype none

module tb_redmule;
  import redmule_pkg::*;

  localparam int unsigned WIDTH      = 4;
  localparam int unsigned HEIGHT     = 4;
  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned TIMEOUT    = 20;
  localparam int unsigned POLL_LIMIT = 40;

  logic        clk;
  logic        rst_n;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer      seed;
  // Operands of the current job, X in row-major order
  elem_t       x_m [WIDTH*HEIGHT];
  elem_t       w_m [HEIGHT];
  elem_t       y_m [WIDTH];

  redmule_top #(
    .Width  ( WIDTH  ),
    .Height ( HEIGHT )
  ) dut (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .awaddr_i  ( awaddr  ),
    .awvalid_i ( awvalid ),
    .awready_o ( awready ),
    .wdata_i   ( wdata   ),
    .wstrb_i   ( wstrb   ),
    .wvalid_i  ( wvalid  ),
    .wready_o  ( wready  ),
    .bresp_o   ( bresp   ),
    .bvalid_o  ( bvalid  ),
    .bready_i  ( bready  ),
    .araddr_i  ( araddr  ),
    .arvalid_i ( arvalid ),
    .arready_o ( arready ),
    .rdata_o   ( rdata   ),
    .rresp_o   ( rresp   ),
    .rvalid_o  ( rvalid  ),
    .rready_i  ( rready  )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%0t ns: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
      abort_run("Value mismatch");
    end
  endtask

  // Handshake rules seen from the master side
  a_aw_w_pair : assert property (@(posedge clk) disable iff (!rst_n)
    awready == wready) else abort_run("awready and wready differ");
  a_aw_needs_both : assert property (@(posedge clk) disable iff (!rst_n)
    awready |-> awvalid && wvalid) else abort_run("awready high without awvalid and wvalid");
  a_b_hold : assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)) else abort_run("bvalid dropped before bready");
  a_ar_idle : assert property (@(posedge clk) disable iff (!rst_n)
    arready == !rvalid) else abort_run("arready does not follow the pending read response");
  a_r_hold : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata)) else abort_run("rvalid dropped before rready");

  // Sampling happens 1 ns after the falling edge, once inputs have settled
  task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    n = 0;
    while (!awready) begin
      if (n == TIMEOUT) abort_run("Timeout waiting for awready");
      n++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    #1;
    n = 0;
    while (!bvalid) begin
      if (n == TIMEOUT) abort_run("Timeout waiting for bvalid");
      n++;
      @(negedge clk);
      #1;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    n = 0;
    while (!arready) begin
      if (n == TIMEOUT) abort_run("Timeout waiting for arready");
      n++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready  = 1'b1;
    #1;
    n = 0;
    while (!rvalid) begin
      if (n == TIMEOUT) abort_run("Timeout waiting for rvalid");
      n++;
      @(negedge clk);
      #1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string name);
    logic [1:0] resp;
    write_word(addr, data, resp);
    check_eq(name, 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_status(output logic [31:0] st);
    logic [1:0] resp;
    read_word(STATUS_ADDR, st, resp);
    check_eq("rresp STATUS", 32'(RESP_OKAY), 32'(resp));
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int n;
    n = 0;
    read_status(st);
    while (!st[1]) begin
      if (n == POLL_LIMIT) abort_run("Timeout waiting for done in STATUS");
      n++;
      read_status(st);
    end
    check_eq("STATUS busy at done", 32'd0, 32'(st[0]));
  endtask

  task automatic randomize_operands();
    for (int i = 0; i < WIDTH * HEIGHT; i++) x_m[i] = 16'($random(seed));
    for (int i = 0; i < HEIGHT; i++) w_m[i] = 16'($random(seed));
    for (int i = 0; i < WIDTH; i++) y_m[i] = 16'($random(seed));
  endtask

  task automatic load_operands(input bit with_w);
    for (int p = 0; p < WIDTH * HEIGHT / 2; p++) begin
      write_expect(X_BASE + 8'(4 * p), {x_m[2*p+1], x_m[2*p]}, RESP_OKAY, "bresp X write");
    end
    for (int p = 0; p < WIDTH / 2; p++) begin
      write_expect(Y_BASE + 8'(4 * p), {y_m[2*p+1], y_m[2*p]}, RESP_OKAY, "bresp Y write");
    end
    if (with_w) begin
      for (int p = 0; p < HEIGHT / 2; p++) begin
        write_expect(W_BASE + 8'(4 * p), {w_m[2*p+1], w_m[2*p]}, RESP_OKAY, "bresp W write");
      end
    end
  endtask

  // Row r of Z = X * W + Y, wrapping at 16 bits
  function automatic elem_t model_z(input int r);
    elem_t acc;
    acc = y_m[r];
    for (int c = 0; c < HEIGHT; c++) begin
      acc = acc + x_m[r*HEIGHT + c] * w_m[c];
    end
    return acc;
  endfunction

  task automatic check_z(input bit expect_zero);
    logic [31:0] rd;
    logic [1:0]  resp;
    logic [31:0] exp;
    for (int j = 0; j < WIDTH / 2; j++) begin
      read_word(Z_BASE + 8'(4 * j), rd, resp);
      exp = expect_zero ? 32'd0 : {model_z(2*j+1), model_z(2*j)};
      check_eq($sformatf("rresp Z word %0d", j), 32'(RESP_OKAY), 32'(resp));
      check_eq($sformatf("rdata Z word %0d", j), exp, rd);
    end
  endtask

  initial begin
    logic [31:0] st;
    logic [31:0] rd;
    logic [1:0]  resp;
    seed    = 32'hef75;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    #1;
    assert (!bvalid && !rvalid) else abort_run("bvalid or rvalid high after reset");
    read_status(st);
    check_eq("STATUS after reset", 32'd0, st);

    // Back-to-back random jobs, done must stay set until the next start
    for (int job = 0; job < 3; job++) begin
      randomize_operands();
      load_operands(1'b1);
      write_expect(TRIGGER_ADDR, 32'h1, RESP_OKAY, "bresp start");
      wait_done();
      read_status(st);
      check_eq("STATUS done sticky", 32'd1, 32'(st[1]));
      check_z(1'b0);
    end

    // Start is ignored without a complete W vector
    write_expect(TRIGGER_ADDR, 32'h2, RESP_OKAY, "bresp clear");
    randomize_operands();
    load_operands(1'b0);
    write_expect(TRIGGER_ADDR, 32'h1, RESP_OKAY, "bresp start without W");
    for (int i = 0; i < 3; i++) begin
      read_status(st);
      check_eq("STATUS after start without W", 32'd0, st);
    end

    // The job is busy for Height+2 cycles, so this write lands inside it
    // before the last column of row 0 reaches the multipliers
    load_operands(1'b1);
    write_expect(TRIGGER_ADDR, 32'h1, RESP_OKAY, "bresp start");
    write_expect(X_BASE + 8'h4, ~{x_m[3], x_m[2]}, RESP_SLVERR, "bresp X write while busy");
    wait_done();
    check_z(1'b0);

    // Unmapped and read-only targets
    read_word(8'h60, rd, resp);
    check_eq("rresp unmapped read", 32'(RESP_SLVERR), 32'(resp));
    check_eq("rdata unmapped read", 32'd0, rd);
    write_expect(Z_BASE, 32'h1234_5678, RESP_SLVERR, "bresp Z write");
    write_expect(STATUS_ADDR, 32'h0, RESP_SLVERR, "bresp STATUS write");
    write_expect(8'h58, 32'h0, RESP_SLVERR, "bresp unmapped write");
    check_z(1'b0);

    // Clear drops done, w_loaded and the accumulators
    read_status(st);
    check_eq("STATUS before clear", 32'h6, st);
    write_expect(TRIGGER_ADDR, 32'h2, RESP_OKAY, "bresp clear");
    read_status(st);
    check_eq("STATUS after clear", 32'd0, st);
    check_z(1'b1);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
redmule_pkg.sv
redmule_load_if.sv
redmule_ctrl_slave.sv
redmule_x_buffer.sv
redmule_w_buffer.sv
redmule_engine.sv
redmule_top.sv
tb_redmule.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds tb_redmule with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_redmule --Mdir obj_dir -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_redmule > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
